// File: design/fpu_macros.svh
/*
 Number format constants for the single-precision multiply unit.
 Included by the packages and by every module that sizes a value by hand.
*/
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

//////////////////////////////
// operand format
//////////////////////////////

// biased exponent, one extra bit for sign of sums
`define FP_EXP_W 10
// fraction with hidden bit
`define FP_FRACT_W 24
// single precision bias
`define FP_BIAS 127
// leading zero count, covers 0..23
`define FP_NLZ_W 5

//////////////////////////////
// multiplier and result
//////////////////////////////

// one half of a padded multiplier operand
`define FP_HALF_W 16
// result fraction incl. trailing sticky bit
`define FP_FRACT_OUT_W 28

`endif

// File: design/fp_operand_pkg.sv
/*
 Types for the unpacked operands that enter the multiply unit.
 Referenced by scoped name from the prenorm and core stages.
*/
`include "fpu_macros.svh"

package fp_operand_pkg;

  //////////////////////////////
  // exponent
  //////////////////////////////

  // biased exponent, wraps in 10 bits
  typedef logic [`FP_EXP_W-1:0] exp10_t;

  //////////////////////////////
  // fraction
  //////////////////////////////

  // fraction with hidden bit on top
  typedef logic [`FP_FRACT_W-1:0] fract24_t;

  // leading zeros of a fraction
  // also the left shift used for normalization
  typedef logic [`FP_NLZ_W-1:0] nlz_t;

endpackage

// File: design/fp_result_pkg.sv
/*
 Types for the multiplier datapath and the align outputs.
 Used by core, align and the top level.
*/
`include "fpu_macros.svh"

package fp_result_pkg;

  // half of a zero padded 32-bit operand
  typedef logic [`FP_HALF_W-1:0] half16_t;

  // product of two halves
  typedef logic [2*`FP_HALF_W-1:0] partial32_t;

  // 27 product bits plus sticky in bit 0
  typedef logic [`FP_FRACT_OUT_W-1:0] fract28_t;

  // right shift for denormal alignment
  // saturates at 31
  typedef logic [`FP_NLZ_W-1:0] shr_t;

endpackage

// File: design/fp_mul_prenorm.sv
/*
 Input stage of the multiplier: exception flags, leading zero counts
 and the stage-0 registers. Feeds fp_mul_core.
*/
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_mul_prenorm (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     adv_i,
  input  logic                     flush_i,
  input  logic                     start_i,
  // operand a
  input  logic                     sign_a_i,
  input  fp_operand_pkg::exp10_t   exp_a_i,
  input  fp_operand_pkg::fract24_t fract_a_i,
  input  logic                     inf_a_i,
  input  logic                     zero_a_i,
  // operand b
  input  logic                     sign_b_i,
  input  fp_operand_pkg::exp10_t   exp_b_i,
  input  fp_operand_pkg::fract24_t fract_b_i,
  input  logic                     inf_b_i,
  input  logic                     zero_b_i,
  // nan info from the unpacker
  input  logic                     snan_i,
  input  logic                     qnan_i,
  input  logic                     anan_sign_i,
  // stage 0
  output logic                     s0_rdy_o,
  output logic                     s0_inv_o,
  output logic                     s0_inf_o,
  output logic                     s0_snan_o,
  output logic                     s0_qnan_o,
  output logic                     s0_anan_sign_o,
  output logic                     s0_zero_o,
  output logic                     s0_sign_o,
  output fp_operand_pkg::exp10_t   s0_exp_a_o,
  output fp_operand_pkg::fract24_t s0_fract_a_o,
  output fp_operand_pkg::nlz_t     s0_nlz_a_o,
  output fp_operand_pkg::exp10_t   s0_exp_b_o,
  output fp_operand_pkg::fract24_t s0_fract_b_o,
  output fp_operand_pkg::nlz_t     s0_nlz_b_o
);

  //////////////////////////////
  // exceptions
  //////////////////////////////

  // 0 * inf is invalid
  logic inv;
  // any inf operand
  logic inf;
  // any zero operand forces zero result
  logic zero;

  assign inv  = (zero_a_i & inf_b_i) | (zero_b_i & inf_a_i);
  assign inf  = inf_a_i | inf_b_i;
  assign zero = zero_a_i | zero_b_i;

  //////////////////////////////
  // leading zeros
  //////////////////////////////

  // highest set bit wins, all zero counts 0
  function automatic fp_operand_pkg::nlz_t count_nlz(input fp_operand_pkg::fract24_t f);
    fp_operand_pkg::nlz_t n;
    n = '0;
    for (int i = 0; i < `FP_FRACT_W; i++) begin
      if (f[i]) begin
        n = fp_operand_pkg::nlz_t'(`FP_FRACT_W - 1 - i);
      end
    end
    return n;
  endfunction

  fp_operand_pkg::nlz_t nlz_a;
  fp_operand_pkg::nlz_t nlz_b;

  assign nlz_a = count_nlz(fract_a_i);
  assign nlz_b = count_nlz(fract_b_i);

  //////////////////////////////
  // stage 0 registers
  //////////////////////////////

  // payload, no reset
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s0_inv_o       <= inv;
      s0_inf_o       <= inf;
      s0_snan_o      <= snan_i;
      s0_qnan_o      <= qnan_i;
      s0_anan_sign_o <= anan_sign_i;
      s0_zero_o      <= zero;
      s0_sign_o      <= sign_a_i ^ sign_b_i;
      s0_exp_a_o     <= exp_a_i;
      s0_fract_a_o   <= fract_a_i;
      s0_nlz_a_o     <= nlz_a;
      s0_exp_b_o     <= exp_b_i;
      s0_fract_b_o   <= fract_b_i;
      s0_nlz_b_o     <= nlz_b;
    end
  end

  // flush beats start
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s0_rdy_o <= 1'b0;
    end else if (flush_i) begin
      s0_rdy_o <= 1'b0;
    end else if (adv_i) begin
      s0_rdy_o <= start_i;
    end
  end

  // valid chain must stay known once out of reset
  assert property (@(posedge clk) disable iff (rst) !$isunknown(s0_rdy_o));

endmodule

// File: design/fp_mul_core.sv
/*
 Normalizes the operands, computes the product exponent and runs the
 two stages of the 16-bit partial product multiplier.
*/
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_mul_core (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     adv_i,
  input  logic                     flush_i,
  // from prenorm
  input  logic                     s0_rdy_i,
  input  logic                     s0_inv_i,
  input  logic                     s0_inf_i,
  input  logic                     s0_snan_i,
  input  logic                     s0_qnan_i,
  input  logic                     s0_anan_sign_i,
  input  logic                     s0_zero_i,
  input  logic                     s0_sign_i,
  input  fp_operand_pkg::exp10_t   s0_exp_a_i,
  input  fp_operand_pkg::fract24_t s0_fract_a_i,
  input  fp_operand_pkg::nlz_t     s0_nlz_a_i,
  input  fp_operand_pkg::exp10_t   s0_exp_b_i,
  input  fp_operand_pkg::fract24_t s0_fract_b_i,
  input  fp_operand_pkg::nlz_t     s0_nlz_b_i,
  // to align
  output logic                     s2_rdy_o,
  output logic                     s2_inv_o,
  output logic                     s2_inf_o,
  output logic                     s2_snan_o,
  output logic                     s2_qnan_o,
  output logic                     s2_anan_sign_o,
  output logic                     s2_zero_o,
  output logic                     s2_sign_o,
  output fp_operand_pkg::exp10_t   s2_exp_o,
  output fp_result_pkg::partial32_t s2_albl_o,
  output fp_result_pkg::partial32_t s2_albh_o,
  output fp_result_pkg::partial32_t s2_ahbl_o,
  output fp_result_pkg::partial32_t s2_ahbh_o
);

  //////////////////////////////
  // normalize and exponent
  //////////////////////////////

  fp_operand_pkg::fract24_t norm_a;
  fp_operand_pkg::fract24_t norm_b;
  fp_operand_pkg::exp10_t   exp_sum;
  fp_operand_pkg::exp10_t   exp_c;

  // shift out leading zeros, clear on zero result
  assign norm_a = (s0_fract_a_i << s0_nlz_a_i) & {`FP_FRACT_W{~s0_zero_i}};
  assign norm_b = (s0_fract_b_i << s0_nlz_b_i) & {`FP_FRACT_W{~s0_zero_i}};

  // ea - nlza + eb - nlzb - bias, wraps negative
  assign exp_sum = s0_exp_a_i - fp_operand_pkg::exp10_t'(s0_nlz_a_i)
                 + s0_exp_b_i - fp_operand_pkg::exp10_t'(s0_nlz_b_i)
                 - fp_operand_pkg::exp10_t'(`FP_BIAS);
  assign exp_c   = s0_zero_i ? '0 : exp_sum;

  //////////////////////////////
  // stage 1
  //////////////////////////////

  logic s1_rdy;
  logic s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan_sign, s1_zero, s1_sign;
  fp_operand_pkg::exp10_t s1_exp;
  // operands padded with 8 zero bits, split in halves
  fp_result_pkg::half16_t s1_al, s1_ah, s1_bl, s1_bh;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_inv       <= s0_inv_i;
      s1_inf       <= s0_inf_i;
      s1_snan      <= s0_snan_i;
      s1_qnan      <= s0_qnan_i;
      s1_anan_sign <= s0_anan_sign_i;
      s1_zero      <= s0_zero_i;
      s1_sign      <= s0_sign_i;
      s1_exp       <= exp_c;
      {s1_ah, s1_al} <= {norm_a, 8'd0};
      {s1_bh, s1_bl} <= {norm_b, 8'd0};
    end
  end

  //////////////////////////////
  // stage 2
  //////////////////////////////

  // four 16x16 partial products
  always_ff @(posedge clk) begin
    if (adv_i) begin
      s2_inv_o       <= s1_inv;
      s2_inf_o       <= s1_inf;
      s2_snan_o      <= s1_snan;
      s2_qnan_o      <= s1_qnan;
      s2_anan_sign_o <= s1_anan_sign;
      s2_zero_o      <= s1_zero;
      s2_sign_o      <= s1_sign;
      s2_exp_o       <= s1_exp;
      s2_albl_o      <= s1_al * s1_bl;
      s2_albh_o      <= s1_al * s1_bh;
      s2_ahbl_o      <= s1_ah * s1_bl;
      s2_ahbh_o      <= s1_ah * s1_bh;
    end
  end

  // ready pipe for both stages
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_rdy   <= 1'b0;
      s2_rdy_o <= 1'b0;
    end else if (flush_i) begin
      s1_rdy   <= 1'b0;
      s2_rdy_o <= 1'b0;
    end else if (adv_i) begin
      s1_rdy   <= s0_rdy_i;
      s2_rdy_o <= s1_rdy;
    end
  end

  // zero flag from prenorm must have cleared the multiplier inputs
  assert property (@(posedge clk) disable iff (rst)
    (s1_rdy && s1_zero) |-> ({s1_ah, s1_al, s1_bh, s1_bl} == '0));

endmodule

// File: design/fp_mul_align.sv
/*
 Output stage: sums the partial products into the 28-bit fraction with
 sticky and computes the right shift needed to align denormal results.
*/
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_mul_align (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      adv_i,
  input  logic                      flush_i,
  // from core
  input  logic                      s2_rdy_i,
  input  logic                      s2_inv_i,
  input  logic                      s2_inf_i,
  input  logic                      s2_snan_i,
  input  logic                      s2_qnan_i,
  input  logic                      s2_anan_sign_i,
  input  logic                      s2_zero_i,
  input  logic                      s2_sign_i,
  input  fp_operand_pkg::exp10_t    s2_exp_i,
  input  fp_result_pkg::partial32_t s2_albl_i,
  input  fp_result_pkg::partial32_t s2_albh_i,
  input  fp_result_pkg::partial32_t s2_ahbl_i,
  input  fp_result_pkg::partial32_t s2_ahbh_i,
  // to rounding
  output logic                      rdy_o,
  output logic                      sign_o,
  output fp_result_pkg::shr_t       shr_o,
  output fp_operand_pkg::exp10_t    exp_shr_o,
  output fp_operand_pkg::exp10_t    exp_sh0_o,
  output fp_result_pkg::fract28_t   fract28_o,
  output logic                      inv_o,
  output logic                      inf_o,
  output logic                      snan_o,
  output logic                      qnan_o,
  output logic                      anan_sign_o
);

  //////////////////////////////
  // product sum
  //////////////////////////////

  // upper 48 bits of the 64-bit product
  logic [47:0] fract48;

  assign fract48 = {s2_ahbh_i, 16'd0}
                 + {16'd0, s2_ahbl_i}
                 + {16'd0, s2_albh_i}
                 + {32'd0, s2_albl_i[31:16]};

  //////////////////////////////
  // right shift
  //////////////////////////////

  logic                   exp_is_0;
  fp_operand_pkg::exp10_t shr_neg;
  fp_operand_pkg::exp10_t shr_wide;
  fp_operand_pkg::exp10_t exp_shr;
  fp_result_pkg::shr_t    shr_sat;

  assign exp_is_0 = (s2_exp_i == '0);
  // 1025 - c for negative sums
  assign shr_neg  = 10'(11'h401 - {1'b0, s2_exp_i});

  always_comb begin
    if (s2_zero_i) begin
      shr_wide = '0;
      exp_shr  = '0;
    end else if (s2_exp_i[`FP_EXP_W-1]) begin
      shr_wide = shr_neg;
      exp_shr  = 10'd1;
    end else begin
      // zero sum still takes one step to denormal
      shr_wide = {9'd0, exp_is_0};
      exp_shr  = s2_exp_i | {9'd0, exp_is_0};
    end
  end

  // anything past 31 shifts everything out
  assign shr_sat = shr_wide[4:0] | {5{|shr_wide[9:5]}};

  //////////////////////////////
  // output registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o      <= s2_sign_i;
      shr_o       <= shr_sat;
      exp_shr_o   <= exp_shr;
      exp_sh0_o   <= s2_exp_i;
      fract28_o   <= {fract48[47:21], |fract48[20:0]};
      inv_o       <= s2_inv_i;
      inf_o       <= s2_inf_i;
      snan_o      <= s2_snan_i;
      qnan_o      <= s2_qnan_i;
      anan_sign_o <= s2_anan_sign_i;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdy_o <= 1'b0;
    end else if (flush_i) begin
      rdy_o <= 1'b0;
    end else if (adv_i) begin
      rdy_o <= s2_rdy_i;
    end
  end

  // a denormal shift always lands on the minimum exponent
  assert property (@(posedge clk) disable iff (rst)
    (rdy_o && shr_o != '0) |-> (exp_shr_o == 10'd1));

endmodule

// File: design/fp_mul_top.sv
/*
 Pipelined single-precision multiply path. Four adv_i cycles from an
 accepted start_i to rdy_o, one operation per stage in flight.
*/
`timescale 1ns/1ps

module fp_mul_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     adv_i,
  input  logic                     flush_i,
  input  logic                     start_i,
  input  logic                     sign_a_i,
  input  fp_operand_pkg::exp10_t   exp_a_i,
  input  fp_operand_pkg::fract24_t fract_a_i,
  input  logic                     inf_a_i,
  input  logic                     zero_a_i,
  input  logic                     sign_b_i,
  input  fp_operand_pkg::exp10_t   exp_b_i,
  input  fp_operand_pkg::fract24_t fract_b_i,
  input  logic                     inf_b_i,
  input  logic                     zero_b_i,
  input  logic                     snan_i,
  input  logic                     qnan_i,
  input  logic                     anan_sign_i,
  output logic                     rdy_o,
  output logic                     sign_o,
  output fp_result_pkg::shr_t      shr_o,
  output fp_operand_pkg::exp10_t   exp_shr_o,
  output fp_operand_pkg::exp10_t   exp_sh0_o,
  output fp_result_pkg::fract28_t  fract28_o,
  output logic                     inv_o,
  output logic                     inf_o,
  output logic                     snan_o,
  output logic                     qnan_o,
  output logic                     anan_sign_o
);

  // prenorm to core
  logic s0_rdy, s0_inv, s0_inf, s0_snan, s0_qnan, s0_anan_sign, s0_zero, s0_sign;
  fp_operand_pkg::exp10_t   s0_exp_a, s0_exp_b;
  fp_operand_pkg::fract24_t s0_fract_a, s0_fract_b;
  fp_operand_pkg::nlz_t     s0_nlz_a, s0_nlz_b;

  // core to align
  logic s2_rdy, s2_inv, s2_inf, s2_snan, s2_qnan, s2_anan_sign, s2_zero, s2_sign;
  fp_operand_pkg::exp10_t    s2_exp;
  fp_result_pkg::partial32_t s2_albl, s2_albh, s2_ahbl, s2_ahbh;

  fp_mul_prenorm u_prenorm (
    .clk, .rst, .adv_i, .flush_i, .start_i,
    .sign_a_i, .exp_a_i, .fract_a_i, .inf_a_i, .zero_a_i,
    .sign_b_i, .exp_b_i, .fract_b_i, .inf_b_i, .zero_b_i,
    .snan_i, .qnan_i, .anan_sign_i,
    .s0_rdy_o       (s0_rdy),
    .s0_inv_o       (s0_inv),
    .s0_inf_o       (s0_inf),
    .s0_snan_o      (s0_snan),
    .s0_qnan_o      (s0_qnan),
    .s0_anan_sign_o (s0_anan_sign),
    .s0_zero_o      (s0_zero),
    .s0_sign_o      (s0_sign),
    .s0_exp_a_o     (s0_exp_a),
    .s0_fract_a_o   (s0_fract_a),
    .s0_nlz_a_o     (s0_nlz_a),
    .s0_exp_b_o     (s0_exp_b),
    .s0_fract_b_o   (s0_fract_b),
    .s0_nlz_b_o     (s0_nlz_b)
  );

  fp_mul_core u_core (
    .clk, .rst, .adv_i, .flush_i,
    .s0_rdy_i       (s0_rdy),
    .s0_inv_i       (s0_inv),
    .s0_inf_i       (s0_inf),
    .s0_snan_i      (s0_snan),
    .s0_qnan_i      (s0_qnan),
    .s0_anan_sign_i (s0_anan_sign),
    .s0_zero_i      (s0_zero),
    .s0_sign_i      (s0_sign),
    .s0_exp_a_i     (s0_exp_a),
    .s0_fract_a_i   (s0_fract_a),
    .s0_nlz_a_i     (s0_nlz_a),
    .s0_exp_b_i     (s0_exp_b),
    .s0_fract_b_i   (s0_fract_b),
    .s0_nlz_b_i     (s0_nlz_b),
    .s2_rdy_o       (s2_rdy),
    .s2_inv_o       (s2_inv),
    .s2_inf_o       (s2_inf),
    .s2_snan_o      (s2_snan),
    .s2_qnan_o      (s2_qnan),
    .s2_anan_sign_o (s2_anan_sign),
    .s2_zero_o      (s2_zero),
    .s2_sign_o      (s2_sign),
    .s2_exp_o       (s2_exp),
    .s2_albl_o      (s2_albl),
    .s2_albh_o      (s2_albh),
    .s2_ahbl_o      (s2_ahbl),
    .s2_ahbh_o      (s2_ahbh)
  );

  fp_mul_align u_align (
    .clk, .rst, .adv_i, .flush_i,
    .s2_rdy_i       (s2_rdy),
    .s2_inv_i       (s2_inv),
    .s2_inf_i       (s2_inf),
    .s2_snan_i      (s2_snan),
    .s2_qnan_i      (s2_qnan),
    .s2_anan_sign_i (s2_anan_sign),
    .s2_zero_i      (s2_zero),
    .s2_sign_i      (s2_sign),
    .s2_exp_i       (s2_exp),
    .s2_albl_i      (s2_albl),
    .s2_albh_i      (s2_albh),
    .s2_ahbl_i      (s2_ahbl),
    .s2_ahbh_i      (s2_ahbh),
    .rdy_o, .sign_o, .shr_o, .exp_shr_o, .exp_sh0_o, .fract28_o,
    .inv_o, .inf_o, .snan_o, .qnan_o, .anan_sign_o
  );

endmodule

// File: test/fp_mul_checker.sv
/*
 Watches the multiply unit, predicts each accepted operation from the
 number format rules and compares results in order as rdy_o marks them.
*/
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fp_mul_checker (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     adv_i,
  input  logic                     flush_i,
  input  logic                     start_i,
  input  logic                     sign_a_i,
  input  fp_operand_pkg::exp10_t   exp_a_i,
  input  fp_operand_pkg::fract24_t fract_a_i,
  input  logic                     inf_a_i,
  input  logic                     zero_a_i,
  input  logic                     sign_b_i,
  input  fp_operand_pkg::exp10_t   exp_b_i,
  input  fp_operand_pkg::fract24_t fract_b_i,
  input  logic                     inf_b_i,
  input  logic                     zero_b_i,
  input  logic                     snan_i,
  input  logic                     qnan_i,
  input  logic                     anan_sign_i,
  // DUT outputs
  input  logic                     rdy_i,
  input  logic                     res_sign_i,
  input  fp_result_pkg::shr_t      res_shr_i,
  input  fp_operand_pkg::exp10_t   res_exp_shr_i,
  input  fp_operand_pkg::exp10_t   res_exp_sh0_i,
  input  fp_result_pkg::fract28_t  res_fract28_i,
  input  logic                     res_inv_i,
  input  logic                     res_inf_i,
  input  logic                     res_snan_i,
  input  logic                     res_qnan_i,
  input  logic                     res_anan_sign_i,
  // run status
  output int                       err_cnt_o,
  output int                       chk_cnt_o,
  output int                       pending_o
);

  typedef struct packed {
    logic                        sign;
    logic [`FP_NLZ_W-1:0]        shr;
    logic [`FP_EXP_W-1:0]        exp_shr;
    logic [`FP_EXP_W-1:0]        exp_sh0;
    logic [`FP_FRACT_OUT_W-1:0]  fract28;
    logic                        inv;
    logic                        inf;
    // snan, qnan, anan_sign
    logic [2:0]                  nan;
  } result_t;

  result_t     exp_q[$];
  // adv count at accept time
  int unsigned tag_q[$];
  int unsigned adv_cnt;
  logic        adv_seen;
  int          errors;
  int          checks;
  int          pending;

  assign err_cnt_o = errors;
  assign chk_cnt_o = checks;
  assign pending_o = pending;

  //////////////////////////////
  // expected result
  //////////////////////////////

  // zeros above the top set bit, 0 for an empty fraction
  function automatic int lead_zeros(input logic [`FP_FRACT_W-1:0] f);
    int n;
    n = 0;
    if (f != '0) begin
      while (!f[`FP_FRACT_W-1-n]) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic result_t predict_result(
    input logic a_sign, input logic [9:0] a_exp, input logic [23:0] a_fract,
    input logic a_inf, input logic a_zero,
    input logic b_sign, input logic [9:0] b_exp, input logic [23:0] b_fract,
    input logic b_inf, input logic b_zero,
    input logic [2:0] nan
  );
    result_t     r;
    logic        zero;
    int          na;
    int          nb;
    logic [23:0] ma;
    logic [23:0] mb;
    logic [47:0] prod;
    logic [9:0]  c;
    int          shift;
    zero = a_zero | b_zero;
    na = lead_zeros(a_fract);
    nb = lead_zeros(b_fract);
    ma = zero ? 24'd0 : a_fract << na;
    mb = zero ? 24'd0 : b_fract << nb;
    prod = {24'd0, ma} * {24'd0, mb};
    // product exponent, wraps in 10 bits
    c = zero ? 10'd0 : 10'(int'(a_exp) - na + int'(b_exp) - nb - `FP_BIAS);
    if (zero) begin
      shift = 0;
      r.exp_shr = 10'd0;
    end else if (c >= 10'd512) begin
      shift = 1025 - int'(c);
      r.exp_shr = 10'd1;
    end else if (c == 10'd0) begin
      shift = 1;
      r.exp_shr = 10'd1;
    end else begin
      shift = 0;
      r.exp_shr = c;
    end
    r.shr     = (shift > 31) ? 5'd31 : 5'(shift);
    r.exp_sh0 = c;
    r.fract28 = {prod[47:21], |prod[20:0]};
    r.sign    = a_sign ^ b_sign;
    r.inv     = (a_zero & b_inf) | (b_zero & a_inf);
    r.inf     = a_inf | b_inf;
    r.nan     = nan;
    return r;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  //////////////////////////////
  // accept side
  //////////////////////////////

  // flush drops everything in flight
  always @(posedge clk or posedge rst) begin
    if (rst) begin
      exp_q.delete();
      tag_q.delete();
      adv_cnt = 0;
      adv_seen = 1'b0;
      pending = 0;
    end else begin
      adv_seen = adv_i;
      if (flush_i) begin
        exp_q.delete();
        tag_q.delete();
      end else if (adv_i && start_i) begin
        exp_q.push_back(predict_result(sign_a_i, exp_a_i, fract_a_i, inf_a_i, zero_a_i,
                                       sign_b_i, exp_b_i, fract_b_i, inf_b_i, zero_b_i,
                                       {snan_i, qnan_i, anan_sign_i}));
        tag_q.push_back(adv_cnt);
      end
      if (adv_i) begin
        adv_cnt++;
      end
      pending = exp_q.size();
    end
  end

  //////////////////////////////
  // result side
  //////////////////////////////

  always @(negedge clk) begin
    result_t     want;
    int unsigned tag;
    if (rst) begin
      compare_field("rdy_o", rdy_i, 1'b0);
    end else if ($isunknown(rdy_i)) begin
      errors++;
      $display("rdy_o is unknown at time %0t", $time);
    end else if (adv_seen && rdy_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result at time %0t with no operation in flight", $time);
      end else begin
        want = exp_q.pop_front();
        tag = tag_q.pop_front();
        pending = exp_q.size();
        checks++;
        if (adv_cnt - tag != 4) begin
          errors++;
          $display("result came %0d adv cycles after start, not 4", adv_cnt - tag);
        end
        compare_field("sign_o", res_sign_i, want.sign);
        compare_field("shr_o", res_shr_i, want.shr);
        compare_field("exp_shr_o", res_exp_shr_i, want.exp_shr);
        compare_field("exp_sh0_o", res_exp_sh0_i, want.exp_sh0);
        compare_field("fract28_o", res_fract28_i, want.fract28);
        compare_field("inv_o", res_inv_i, want.inv);
        compare_field("inf_o", res_inf_i, want.inf);
        compare_field("snan_o", res_snan_i, want.nan[2]);
        compare_field("qnan_o", res_qnan_i, want.nan[1]);
        compare_field("anan_sign_o", res_anan_sign_i, want.nan[0]);
      end
    end
  end

endmodule

// File: test/tb_fp_mul.sv
/*
 Testbench top for the multiply path. Generates clock, reset and operand
 stimulus on falling edges; fp_mul_checker does all the comparing.
*/
`timescale 1ns/1ps

module tb_fp_mul;

  // one operand as the unpacker hands it over
  typedef struct packed {
    logic        sign;
    logic [9:0]  exp;
    logic [23:0] fract;
    logic        inf;
    logic        zero;
  } operand_t;

  // cycles any single wait may take
  localparam int WAIT_LIMIT = 200;

  logic clk;
  logic rst;
  logic adv_i, flush_i, start_i;
  logic sign_a_i, inf_a_i, zero_a_i;
  logic sign_b_i, inf_b_i, zero_b_i;
  fp_operand_pkg::exp10_t   exp_a_i, exp_b_i;
  fp_operand_pkg::fract24_t fract_a_i, fract_b_i;
  logic snan_i, qnan_i, anan_sign_i;

  logic rdy_o, sign_o, inv_o, inf_o, snan_o, qnan_o, anan_sign_o;
  fp_result_pkg::shr_t     shr_o;
  fp_operand_pkg::exp10_t  exp_shr_o, exp_sh0_o;
  fp_result_pkg::fract28_t fract28_o;

  int   errors, checks, pending;
  // random adv_i when set
  logic stall_en;
  // some wait ran out
  logic hung;

  always #4 clk = ~clk;

  fp_mul_top UUT (.*);

  fp_mul_checker u_checker (
    .clk, .rst, .adv_i, .flush_i, .start_i,
    .sign_a_i, .exp_a_i, .fract_a_i, .inf_a_i, .zero_a_i,
    .sign_b_i, .exp_b_i, .fract_b_i, .inf_b_i, .zero_b_i,
    .snan_i, .qnan_i, .anan_sign_i,
    .rdy_i             (rdy_o),
    .res_sign_i        (sign_o),
    .res_shr_i         (shr_o),
    .res_exp_shr_i     (exp_shr_o),
    .res_exp_sh0_i     (exp_sh0_o),
    .res_fract28_i     (fract28_o),
    .res_inv_i         (inv_o),
    .res_inf_i         (inf_o),
    .res_snan_i        (snan_o),
    .res_qnan_i        (qnan_o),
    .res_anan_sign_i   (anan_sign_o),
    .err_cnt_o         (errors),
    .chk_cnt_o         (checks),
    .pending_o         (pending)
  );

  //////////////////////////////
  // operand makers
  //////////////////////////////

  // hidden bit set and exponent in range
  function automatic operand_t normal_op(input int exp_lo, input int exp_hi);
    operand_t o;
    o.sign  = 1'($urandom_range(1, 0));
    o.exp   = 10'($urandom_range(exp_hi, exp_lo));
    o.fract = {1'b1, 23'($urandom())};
    o.inf   = 1'b0;
    o.zero  = 1'b0;
    return o;
  endfunction

  // 1..23 leading zeros and never all zero
  function automatic operand_t shifted_op();
    operand_t o;
    o = normal_op(100, 200);
    o.fract = o.fract >> $urandom_range(23, 1);
    return o;
  endfunction

  function automatic operand_t zero_op();
    operand_t o;
    o = '0;
    o.sign = 1'($urandom_range(1, 0));
    o.zero = 1'b1;
    return o;
  endfunction

  function automatic operand_t inf_op();
    operand_t o;
    o = '0;
    o.sign  = 1'($urandom_range(1, 0));
    o.exp   = 10'h0ff;
    o.fract = 24'h800000;
    o.inf   = 1'b1;
    return o;
  endfunction

  //////////////////////////////
  // drive tasks
  //////////////////////////////

  // waits one falling edge and sets adv_i for the next rising edge
  task automatic next_cycle();
    @(negedge clk);
    if (stall_en) begin
      adv_i = ($urandom_range(3, 0) != 0);
    end else begin
      adv_i = 1'b1;
    end
  endtask

  // present start_i until an adv_i edge takes it
  task automatic send_op(input operand_t a, input operand_t b, input logic [2:0] nan);
    int waited;
    waited = 0;
    next_cycle();
    {sign_a_i, exp_a_i, fract_a_i, inf_a_i, zero_a_i} = a;
    {sign_b_i, exp_b_i, fract_b_i, inf_b_i, zero_b_i} = b;
    {snan_i, qnan_i, anan_sign_i} = nan;
    start_i = 1'b1;
    while (!adv_i && !hung) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: start was never accepted by an adv cycle");
        hung = 1'b1;
      end else begin
        next_cycle();
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      next_cycle();
      start_i = 1'b0;
    end
  endtask

  // wait for every queued result
  task automatic drain();
    int waited;
    waited = 0;
    next_cycle();
    start_i = 1'b0;
    while (pending != 0 && !hung) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: %0d expected results never appeared", pending);
        hung = 1'b1;
      end else begin
        next_cycle();
      end
    end
  endtask

  task automatic report_end();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, hung);
    if (errors == 0 && !hung && checks > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'hfe1f));
    clk = 1'b0;
    rst = 1'b1;
    {adv_i, flush_i, start_i} = '0;
    {sign_a_i, exp_a_i, fract_a_i, inf_a_i, zero_a_i} = '0;
    {sign_b_i, exp_b_i, fract_b_i, inf_b_i, zero_b_i} = '0;
    {snan_i, qnan_i, anan_sign_i} = '0;
    stall_en = 1'b0;
    hung = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // back to back normal operands
    for (int i = 0; i < 24; i++) begin
      send_op(normal_op(64, 190), normal_op(64, 190), 3'b000);
    end
    drain();

    // leading zeros on one or both sides
    for (int i = 0; i < 12; i++) begin
      send_op(shifted_op(), normal_op(100, 200), 3'b000);
      send_op(shifted_op(), shifted_op(), 3'b000);
    end
    drain();

    // zero, inf and nan flags
    send_op(zero_op(), inf_op(), 3'b000);
    send_op(inf_op(), zero_op(), 3'b101);
    send_op(inf_op(), normal_op(1, 250), 3'b010);
    send_op(normal_op(1, 250), zero_op(), 3'b011);
    send_op(zero_op(), zero_op(), 3'b000);
    send_op(inf_op(), inf_op(), 3'b000);
    for (int i = 0; i < 8; i++) begin
      send_op(normal_op(60, 200), normal_op(60, 200), 3'($urandom()));
    end
    drain();

    // sums at zero, just below and far below
    send_op(normal_op(63, 63), normal_op(64, 64), 3'b000);
    send_op(normal_op(1, 1), normal_op(1, 1), 3'b000);
    for (int i = 0; i < 16; i++) begin
      send_op(normal_op(1, 70), normal_op(1, 70), 3'b000);
    end
    drain();

    // random stalls with a mix of everything
    stall_en = 1'b1;
    for (int i = 0; i < 30; i++) begin
      if (i % 5 == 0) begin
        send_op(shifted_op(), zero_op(), 3'($urandom()));
      end else begin
        send_op(normal_op(1, 250), shifted_op(), 3'($urandom()));
      end
    end
    drain();

    // flush with work in flight
    for (int i = 0; i < 3; i++) begin
      send_op(normal_op(64, 190), normal_op(64, 190), 3'b000);
    end
    next_cycle();
    // adv_i high so only flush priority can drop this start
    adv_i   = 1'b1;
    start_i = 1'b1;
    flush_i = 1'b1;
    next_cycle();
    start_i = 1'b0;
    flush_i = 1'b0;
    idle(12);
    drain();

    // pipe still works after the flush
    stall_en = 1'b0;
    for (int i = 0; i < 6; i++) begin
      send_op(normal_op(64, 190), shifted_op(), 3'b000);
    end
    drain();
    report_end();
  end

endmodule

// File: flist.f
+incdir+design
design/fp_operand_pkg.sv
design/fp_result_pkg.sv
design/fp_mul_prenorm.sv
design/fp_mul_core.sv
design/fp_mul_align.sv
design/fp_mul_top.sv
test/fp_mul_checker.sv
test/tb_fp_mul.sv

// File: Makefile
# Verilator simulation of the pipelined multiply path

TOP := tb_fp_mul
OBJ := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) -Mdir $(OBJ)

# pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)
